// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= alu_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Done: no errors$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+design
design/alu_pkg.sv
design/alu_operand_if.sv
design/alu_result_if.sv
design/alu_compute.sv
design/branch_eval.sv
design/alu_regs.sv
design/alu_top.sv
tb/tb_clock.sv
tb/alu_tb.sv

// ==== design/alu_compute.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "alu_params.svh"

module alu_compute (
	alu_operand_if.sink operand,
	alu_exec_if.producer exec
);

	logic c;
	logic cin;
	logic [`ALU_DATA_W:0] sum;
	logic [4:0] nib;
	logic [`ALU_DATA_W-1:0] step;

	assign c = operand.psw[`ALU_PSW_C];

	// carry only enters addc and subb.
	assign cin = (operand.opcode == `ALU_ADDC || operand.opcode == `ALU_SUBB) ? c : 1'b0;

	// subb borrows land in the top bit, same as a carry.
	assign sum = (operand.opcode == `ALU_SUBB) ?
		({1'b0, operand.a} - {1'b0, operand.operand} - {{`ALU_DATA_W{1'b0}}, cin}) :
		({1'b0, operand.a} + {1'b0, operand.operand} + {{`ALU_DATA_W{1'b0}}, cin});

	assign nib = (operand.opcode == `ALU_SUBB) ?
		({1'b0, operand.a[3:0]} - {1'b0, operand.operand[3:0]} - {4'b0, cin}) :
		({1'b0, operand.a[3:0]} + {1'b0, operand.operand[3:0]} + {4'b0, cin});

	// plus one or minus one.
	assign step = (operand.opcode == `ALU_INC) ? `ALU_DATA_W'd1 : {`ALU_DATA_W{1'b1}};

	always_comb begin
		exec.a_next = operand.a;
		exec.b_next = operand.b;
		exec.psw_next = operand.psw;
		exec.data_we = 1'b0;
		exec.data = '0;
		if (operand.valid) begin
			case (operand.opcode)
				`ALU_ADD, `ALU_ADDC, `ALU_SUBB: begin
					exec.a_next = sum[`ALU_DATA_W-1:0];
					exec.psw_next[`ALU_PSW_C] = sum[`ALU_DATA_W];
					exec.psw_next[`ALU_PSW_AC] = nib[4];
					exec.psw_next[`ALU_PSW_OV] = sum[`ALU_DATA_W] ^ sum[`ALU_DATA_W-1];
				end
				`ALU_INC, `ALU_DEC: begin
					if (operand.sfr_src && operand.sfr_sel == `ALU_SFR_A) begin
						exec.a_next = operand.a + step;
					end
					else if (operand.sfr_src && operand.sfr_sel == `ALU_SFR_B) begin
						exec.b_next = operand.b + step;
					end
					else begin
						exec.data_we = 1'b1; // result goes out on des_data.
						exec.data = operand.src_data + step;
					end
					exec.psw_next[`ALU_PSW_C] = 1'b0;
				end
				`ALU_ANL: begin
					exec.a_next = operand.a & operand.operand;
				end
				`ALU_ORL: begin
					exec.a_next = operand.a | operand.operand;
				end
				`ALU_XRL: begin
					exec.a_next = operand.a ^ operand.operand;
				end
				`ALU_CLR: begin
					exec.a_next = '0;
				end
				`ALU_CPL: begin
					exec.a_next = ~operand.a;
				end
				`ALU_RR: begin
					exec.a_next = {operand.a[0], operand.a[`ALU_DATA_W-1:1]};
				end
				`ALU_RL: begin
					exec.a_next = {operand.a[`ALU_DATA_W-2:0], operand.a[`ALU_DATA_W-1]};
				end
				`ALU_RRC: begin
					exec.a_next = {c, operand.a[`ALU_DATA_W-1:1]};
					exec.psw_next[`ALU_PSW_C] = operand.a[0];
				end
				`ALU_RLC: begin
					exec.a_next = {operand.a[`ALU_DATA_W-2:0], c};
					exec.psw_next[`ALU_PSW_C] = operand.a[`ALU_DATA_W-1];
				end
				`ALU_SWAP: begin
					exec.a_next = {operand.a[3:0], operand.a[7:4]};
				end
				`ALU_MOV: begin
					exec.a_next = operand.operand;
				end
				default: begin
					// branches and unused codes keep state.
					exec.a_next = operand.a;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/alu_operand_if.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "alu_params.svh"

interface alu_operand_if;
	logic valid;
	logic [`ALU_OPCODE_W-1:0] opcode;
	logic [`ALU_DATA_W-1:0] operand; // resolved source byte.
	logic [`ALU_SFR_SEL_W-1:0] sfr_sel;
	logic sfr_src;
	logic [`ALU_DATA_W-1:0] src_data; // raw bus byte.
	logic [`ALU_DATA_W-1:0] a;
	logic [`ALU_DATA_W-1:0] b;
	logic [`ALU_DATA_W-1:0] psw;

	modport source (
		output valid, opcode, operand, sfr_sel, sfr_src, src_data, a, b, psw
	);

	modport sink (
		input valid, opcode, operand, sfr_sel, sfr_src, src_data, a, b, psw
	);
endinterface

`default_nettype wire

// ==== design/alu_params.svh ====
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

`define ALU_DATA_W      8
`define ALU_OPCODE_W    6
`define ALU_SRC_DESC_W  12
`define ALU_SRC_KIND_W  2
`define ALU_SFR_SEL_W   2

// arithmetic unit, code 000
`define ALU_ADD   6'b000_000
`define ALU_ADDC  6'b000_001
`define ALU_SUBB  6'b000_010
`define ALU_INC   6'b000_011
`define ALU_DEC   6'b000_100

// logic unit, code 001
`define ALU_ANL   6'b001_000
`define ALU_ORL   6'b001_001
`define ALU_XRL   6'b001_010
`define ALU_CLR   6'b001_011
`define ALU_CPL   6'b001_100

// transfer unit, code 010
`define ALU_RR    6'b010_000
`define ALU_RL    6'b010_001
`define ALU_RRC   6'b010_010
`define ALU_RLC   6'b010_011
`define ALU_SWAP  6'b010_100
`define ALU_MOV   6'b010_101

// branch unit, code 011
`define ALU_JZ    6'b011_000
`define ALU_JNZ   6'b011_001
`define ALU_JC    6'b011_010
`define ALU_JNC   6'b011_011
`define ALU_CJNE  6'b011_100
`define ALU_DJNZ  6'b011_101

`define ALU_PSW_C   7
`define ALU_PSW_AC  6
`define ALU_PSW_OV  2

`define ALU_SRC_DATA  2'b00
`define ALU_SRC_IMM   2'b10
`define ALU_SRC_SFR   2'b11

`define ALU_SFR_A    2'b10
`define ALU_SFR_B    2'b01
`define ALU_SFR_PSW  2'b11

`endif

// ==== design/alu_pkg.sv ====
`default_nettype none
`include "alu_params.svh"

package alu_pkg;

	// one source word, read as immediate or as special-register select.
	typedef union packed {
		struct packed {
			logic [`ALU_SRC_KIND_W-1:0] kind;
			logic [`ALU_SRC_DESC_W-`ALU_SRC_KIND_W-`ALU_DATA_W-1:0] spare;
			logic [`ALU_DATA_W-1:0] imm;
		} imm_view;
		struct packed {
			logic [`ALU_SRC_KIND_W-1:0] kind;
			logic [`ALU_SRC_DESC_W-`ALU_SRC_KIND_W-`ALU_SFR_SEL_W-1:0] spare;
			logic [`ALU_SFR_SEL_W-1:0] sel;
		} sfr_view;
	} src_desc_u;

endpackage

`default_nettype wire

// ==== design/alu_regs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "alu_params.svh"

module alu_regs
	import alu_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic nop,
	input  logic [`ALU_OPCODE_W-1:0] opcode,
	input  logic [`ALU_DATA_W-1:0] src_data,
	input  src_desc_u src_desc,
	alu_operand_if.source operand,
	alu_exec_if.consumer exec,
	alu_branch_if.consumer branch,
	output logic [`ALU_DATA_W-1:0] des_data,
	output logic [`ALU_DATA_W-1:0] a,
	output logic [`ALU_DATA_W-1:0] b,
	output logic [`ALU_DATA_W-1:0] psw
);

	logic [`ALU_SRC_KIND_W-1:0] kind;
	logic [`ALU_DATA_W-1:0] sfr_val;
	logic [`ALU_DATA_W-1:0] src_val;
	logic [`ALU_DATA_W-1:0] psw_next;

	assign kind = src_desc.imm_view.kind; // same bits in both views.

	always_comb begin
		case (src_desc.sfr_view.sel)
			`ALU_SFR_A: sfr_val = a;
			`ALU_SFR_B: sfr_val = b;
			`ALU_SFR_PSW: sfr_val = psw;
			default: sfr_val = '0;
		endcase
	end

	always_comb begin
		case (kind)
			`ALU_SRC_SFR: src_val = sfr_val;
			`ALU_SRC_IMM: src_val = src_desc.imm_view.imm;
			`ALU_SRC_DATA: src_val = src_data;
			default: src_val = src_data;
		endcase
	end

	// nothing issues while in reset.
	assign operand.valid = ~nop & ~reset;
	assign operand.opcode = opcode;
	assign operand.operand = src_val;
	assign operand.sfr_src = kind == `ALU_SRC_SFR;
	assign operand.sfr_sel = (kind == `ALU_SRC_SFR) ? src_desc.sfr_view.sel : '0;
	assign operand.src_data = src_data;
	assign operand.a = a;
	assign operand.b = b;
	assign operand.psw = psw;

	always_comb begin
		psw_next = exec.psw_next;
		if (branch.carry_we) begin
			psw_next[`ALU_PSW_C] = branch.carry; // cjne compare result.
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			a <= '0;
			b <= '0;
			psw <= '0;
			des_data <= '0;
		end
		else begin
			a <= exec.a_next;
			b <= exec.b_next;
			psw <= psw_next;
			if (exec.data_we) begin
				des_data <= exec.data;
			end
			else if (branch.data_we) begin
				des_data <= branch.data;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/alu_result_if.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "alu_params.svh"

interface alu_exec_if;
	logic [`ALU_DATA_W-1:0] a_next;
	logic [`ALU_DATA_W-1:0] b_next;
	logic [`ALU_DATA_W-1:0] psw_next;
	logic data_we;
	logic [`ALU_DATA_W-1:0] data;

	modport producer (
		output a_next, b_next, psw_next, data_we, data
	);

	modport consumer (
		input a_next, b_next, psw_next, data_we, data
	);
endinterface

interface alu_branch_if;
	logic valid;
	logic taken;
	logic carry_we; // cjne carry update.
	logic carry;
	logic data_we;
	logic [`ALU_DATA_W-1:0] data;

	modport producer (
		output valid, taken, carry_we, carry, data_we, data
	);

	modport consumer (
		input valid, taken, carry_we, carry, data_we, data
	);
endinterface

`default_nettype wire

// ==== design/alu_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "alu_params.svh"

module alu_top
	import alu_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic nop,
	input  logic [`ALU_OPCODE_W-1:0] opcode,
	input  logic [`ALU_DATA_W-1:0] src_data,
	input  src_desc_u src_desc,
	output logic branch_valid,
	output logic branch_taken,
	output logic [`ALU_DATA_W-1:0] des_data,
	output logic [`ALU_DATA_W-1:0] a,
	output logic [`ALU_DATA_W-1:0] b,
	output logic [`ALU_DATA_W-1:0] psw
);

	alu_operand_if operand_bus ();
	alu_exec_if exec_bus ();
	alu_branch_if branch_bus ();

	alu_regs u_regs (
		.clk      (clk),
		.reset    (reset),
		.nop      (nop),
		.opcode   (opcode),
		.src_data (src_data),
		.src_desc (src_desc),
		.operand  (operand_bus),
		.exec     (exec_bus),
		.branch   (branch_bus),
		.des_data (des_data),
		.a        (a),
		.b        (b),
		.psw      (psw)
	);

	alu_compute u_compute (.operand(operand_bus), .exec(exec_bus));

	branch_eval u_branch (.operand(operand_bus), .branch(branch_bus));

	assign branch_valid = branch_bus.valid;
	assign branch_taken = branch_bus.taken;

endmodule

`default_nettype wire

// ==== design/branch_eval.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "alu_params.svh"

module branch_eval (
	alu_operand_if.sink operand,
	alu_branch_if.producer branch
);

	logic [`ALU_DATA_W-1:0] dec;
	logic c;

	assign dec = operand.operand - `ALU_DATA_W'd1; // djnz counter.
	assign c = operand.psw[`ALU_PSW_C];

	always_comb begin
		branch.valid = 1'b0;
		branch.taken = 1'b0;
		branch.carry_we = 1'b0;
		branch.carry = 1'b0;
		branch.data_we = 1'b0;
		branch.data = '0;
		if (operand.valid) begin
			case (operand.opcode)
				`ALU_JZ: begin
					branch.valid = 1'b1;
					branch.taken = ~|operand.a;
				end
				`ALU_JNZ: begin
					branch.valid = 1'b1;
					branch.taken = |operand.a;
				end
				`ALU_JC: begin
					branch.valid = 1'b1;
					branch.taken = c;
				end
				`ALU_JNC: begin
					branch.valid = 1'b1;
					branch.taken = ~c;
				end
				`ALU_CJNE: begin
					branch.valid = 1'b1;
					branch.taken = operand.a != operand.operand;
					branch.carry_we = operand.a != operand.operand; // equal leaves c.
					branch.carry = operand.a < operand.operand;
				end
				`ALU_DJNZ: begin
					branch.valid = 1'b1;
					branch.taken = |dec;
					branch.data_we = 1'b1;
					branch.data = dec;
				end
				default: begin
					branch.valid = 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tb/alu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "alu_params.svh"

module alu_tb
	import alu_pkg::*;
();

	localparam int PERIOD = 10;
	localparam int ROUNDS = 4;
	localparam int NUM_VECTORS = 120 * ROUNDS + 14; // applied instructions.
	localparam int LIMIT_NS = (NUM_VECTORS * 20 + 100) * PERIOD;
	localparam logic [5:0] ARITH_OPS [3] = '{`ALU_ADD, `ALU_ADDC, `ALU_SUBB};
	localparam logic [5:0] MOVE_OPS [11] = '{`ALU_ANL, `ALU_ORL, `ALU_XRL, `ALU_CLR,
		`ALU_CPL, `ALU_RR, `ALU_RL, `ALU_RRC, `ALU_RLC, `ALU_SWAP, `ALU_MOV};
	localparam logic [5:0] BRANCH_OPS [6] = '{`ALU_JZ, `ALU_JNZ, `ALU_JC, `ALU_JNC,
		`ALU_CJNE, `ALU_DJNZ};

	logic clk;
	logic reset;
	logic nop;
	logic [5:0] opcode;
	logic [7:0] src_data;
	src_desc_u src_desc;
	logic branch_valid;
	logic branch_taken;
	logic [7:0] des_data;
	logic [7:0] a;
	logic [7:0] b;
	logic [7:0] psw;

	// model state, advanced by the compare process.
	logic [7:0] m_a, m_b, m_psw, m_des;
	logic [7:0] nx_a, nx_b, nx_psw, nx_des;
	logic exp_valid;
	logic exp_taken;
	logic model_ok = 1'b0;
	logic mov_pending = 1'b0;
	src_desc_u mov_desc;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start = 0;
	logic [7:0] aval;
	logic [7:0] opnd;

	tb_clock #(.PERIOD(PERIOD)) clk_gen (.clk(clk));

	alu_top dut_i (
		.clk          (clk),
		.reset        (reset),
		.nop          (nop),
		.opcode       (opcode),
		.src_data     (src_data),
		.src_desc     (src_desc),
		.branch_valid (branch_valid),
		.branch_taken (branch_taken),
		.des_data     (des_data),
		.a            (a),
		.b            (b),
		.psw          (psw)
	);

	function automatic void alu_ref(
		input logic [5:0] op,
		input src_desc_u desc,
		input logic [7:0] data,
		input logic idle,
		input logic [7:0] ra, rb, rpsw, rdes,
		output logic bv, bt,
		output logic [7:0] na, nb, npsw, ndes
	);
		logic [7:0] src;
		logic is_sfr;
		logic c;
		logic cin;
		int r;
		int rn;
		src = (desc.imm_view.kind == `ALU_SRC_IMM) ? desc.imm_view.imm : data;
		is_sfr = desc.sfr_view.kind == `ALU_SRC_SFR;
		if (is_sfr) begin
			case (desc.sfr_view.sel)
				`ALU_SFR_A: src = ra;
				`ALU_SFR_B: src = rb;
				`ALU_SFR_PSW: src = rpsw;
				default: src = 8'h00;
			endcase
		end
		c = rpsw[`ALU_PSW_C];
		cin = (op == `ALU_ADDC || op == `ALU_SUBB) && c;
		bv = !idle && op[5:3] == 3'b011; // branch unit code.
		bt = 1'b0;
		na = ra;
		nb = rb;
		npsw = rpsw;
		ndes = rdes;
		if (!idle) begin
			case (op)
				`ALU_ADD, `ALU_ADDC: begin
					r = int'(ra) + int'(src) + int'(cin);
					rn = int'(ra[3:0]) + int'(src[3:0]) + int'(cin);
					na = r[7:0];
					npsw[`ALU_PSW_C] = r > 255;
					npsw[`ALU_PSW_AC] = rn > 15;
					npsw[`ALU_PSW_OV] = (r > 255) ^ r[7];
				end
				`ALU_SUBB: begin
					r = int'(ra) - int'(src) - int'(cin);
					rn = int'(ra[3:0]) - int'(src[3:0]) - int'(cin);
					na = r[7:0]; // borrow wraps like hardware.
					npsw[`ALU_PSW_C] = r < 0;
					npsw[`ALU_PSW_AC] = rn < 0;
					npsw[`ALU_PSW_OV] = (r < 0) ^ r[7];
				end
				`ALU_INC, `ALU_DEC: begin
					if (is_sfr && desc.sfr_view.sel == `ALU_SFR_A)
						na = (op == `ALU_INC) ? ra + 8'd1 : ra - 8'd1;
					else if (is_sfr && desc.sfr_view.sel == `ALU_SFR_B)
						nb = (op == `ALU_INC) ? rb + 8'd1 : rb - 8'd1;
					else
						ndes = (op == `ALU_INC) ? data + 8'd1 : data - 8'd1;
					npsw[`ALU_PSW_C] = 1'b0;
				end
				`ALU_ANL: na = ra & src;
				`ALU_ORL: na = ra | src;
				`ALU_XRL: na = ra ^ src;
				`ALU_CLR: na = 8'h00;
				`ALU_CPL: na = ~ra;
				`ALU_RR: na = {ra[0], ra[7:1]};
				`ALU_RL: na = {ra[6:0], ra[7]};
				`ALU_RRC: begin
					na = {c, ra[7:1]};
					npsw[`ALU_PSW_C] = ra[0];
				end
				`ALU_RLC: begin
					na = {ra[6:0], c};
					npsw[`ALU_PSW_C] = ra[7];
				end
				`ALU_SWAP: na = {ra[3:0], ra[7:4]};
				`ALU_MOV: na = src;
				`ALU_JZ: bt = ra == 8'h00;
				`ALU_JNZ: bt = ra != 8'h00;
				`ALU_JC: bt = c;
				`ALU_JNC: bt = !c;
				`ALU_CJNE: begin
					bt = ra != src;
					if (ra != src)
						npsw[`ALU_PSW_C] = ra < src;
				end
				`ALU_DJNZ: begin
					ndes = src - 8'd1;
					bt = ndes != 8'h00;
				end
				default: ;
			endcase
		end
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_branch(input logic got_v, got_t, exp_v, exp_t);
		checks++;
		if (got_v !== exp_v || got_t !== exp_t) begin
			errors++;
			$display("[FAIL] %0t branch_valid/branch_taken: got %b/%b, expected %b/%b",
				$time, got_v, got_t, exp_v, exp_t);
		end
	endtask

	task automatic check_desc(input src_desc_u got, input src_desc_u exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t src_desc: got %h, expected %h", $time, got, exp);
		end
	endtask

	function automatic logic [7:0] rand_byte();
		return 8'($urandom);
	endfunction

	function automatic logic [1:0] rand_sel();
		case ($urandom_range(0, 2))
			0: return `ALU_SFR_A;
			1: return `ALU_SFR_B;
			default: return `ALU_SFR_PSW;
		endcase
	endfunction

	function automatic src_desc_u imm_desc(input logic [7:0] v);
		src_desc_u d;
		d = '0;
		d.imm_view.kind = `ALU_SRC_IMM;
		d.imm_view.imm = v;
		return d;
	endfunction

	function automatic src_desc_u sfr_desc(input logic [1:0] sel);
		src_desc_u d;
		d = '0;
		d.sfr_view.kind = `ALU_SRC_SFR;
		d.sfr_view.sel = sel;
		return d;
	endfunction

	// 0 data bus, 1 random immediate, 2 random special register.
	function automatic src_desc_u pick_desc(input int kind);
		src_desc_u d;
		d = '0;
		d.imm_view.kind = `ALU_SRC_DATA;
		if (kind == 1)
			d = imm_desc(rand_byte());
		else if (kind == 2)
			d = sfr_desc(rand_sel());
		return d;
	endfunction

	task automatic apply(input logic [5:0] op, input src_desc_u desc, input logic [7:0] data,
		input logic idle);
		@(posedge clk);
		opcode <= op;
		src_desc <= desc;
		src_data <= data;
		nop <= idle;
	endtask

	task automatic finish_test(input string name);
		@(posedge clk);
		nop <= 1'b1;
		@(negedge clk);
		@(posedge clk); // last register check has run.
		tests_run++;
		if (errors != test_start)
			tests_failed++;
		$display("test %s: %s, %0d errors", name, (errors == test_start) ? "ok" : "FAILED",
			errors - test_start);
		test_start = errors;
	endtask

	// registers from the previous instruction, then branch outputs of this one.
	initial begin
		@(posedge clk);
		forever begin
			@(negedge clk);
			if (model_ok) begin
				check_byte("a", a, m_a);
				check_byte("b", b, m_b);
				check_byte("psw", psw, m_psw);
				check_byte("des_data", des_data, m_des);
				if (mov_pending)
					check_desc(imm_desc(a), mov_desc);
			end
			mov_pending = 1'b0;
			if (reset) begin
				check_branch(branch_valid, branch_taken, 1'b0, 1'b0);
				m_a = 8'h00;
				m_b = 8'h00;
				m_psw = 8'h00;
				m_des = 8'h00;
				model_ok = 1'b1;
			end
			else begin
				alu_ref(opcode, src_desc, src_data, nop, m_a, m_b, m_psw, m_des,
					exp_valid, exp_taken, nx_a, nx_b, nx_psw, nx_des);
				check_branch(branch_valid, branch_taken, exp_valid, exp_taken);
				if (!nop && opcode == `ALU_MOV && src_desc.imm_view.kind == `ALU_SRC_IMM) begin
					mov_pending = 1'b1;
					mov_desc = src_desc;
				end
				m_a = nx_a;
				m_b = nx_b;
				m_psw = nx_psw;
				m_des = nx_des;
			end
		end
	end

	initial begin
		#(LIMIT_NS);
		$display("watchdog: run did not finish within %0d ns", LIMIT_NS);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		void'($urandom(32'h1d07));
		reset = 1'b1;
		nop = 1'b1;
		opcode = `ALU_MOV;
		src_data = 8'h00;
		src_desc = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		check_byte("a", a, 8'h00);
		check_byte("b", b, 8'h00);
		check_byte("psw", psw, 8'h00);
		check_byte("des_data", des_data, 8'h00);
		check_branch(branch_valid, branch_taken, 1'b0, 1'b0);
		finish_test("reset");

		for (int r = 0; r < ROUNDS; r++) begin
			apply(`ALU_MOV, imm_desc(rand_byte()), 8'h00, 1'b0);
			for (int k = 0; k < 3; k++) begin
				for (int i = 0; i < 3; i++)
					apply(ARITH_OPS[i], pick_desc(k), rand_byte(), 1'b0);
			end
		end
		finish_test("arith");

		for (int r = 0; r < ROUNDS; r++) begin
			for (int k = 0; k < 3; k++) begin
				for (int i = 0; i < 11; i++) begin
					apply(`ALU_MOV, imm_desc(rand_byte()), 8'h00, 1'b0);
					apply(MOVE_OPS[i], pick_desc(k), rand_byte(), 1'b0);
				end
			end
		end
		finish_test("logic");

		for (int r = 0; r < ROUNDS; r++) begin
			for (int i = 0; i < 2; i++) begin
				apply(`ALU_ADD, imm_desc(rand_byte()), 8'h00, 1'b0); // sets c now and then.
				apply(i ? `ALU_DEC : `ALU_INC, sfr_desc(`ALU_SFR_A), rand_byte(), 1'b0);
				apply(i ? `ALU_DEC : `ALU_INC, sfr_desc(`ALU_SFR_B), rand_byte(), 1'b0);
				apply(i ? `ALU_DEC : `ALU_INC, pick_desc(r % 2), rand_byte(), 1'b0);
			end
		end
		finish_test("inc_dec");

		for (int r = 0; r < ROUNDS * 2; r++) begin
			for (int i = 0; i < 6; i++) begin
				aval = ($urandom_range(0, 3) == 0) ? 8'h00 : rand_byte();
				case ($urandom_range(0, 2))
					0: opnd = aval;
					1: opnd = 8'h01;
					default: opnd = rand_byte();
				endcase
				apply(`ALU_ADD, imm_desc(rand_byte()), 8'h00, 1'b0);
				apply(`ALU_MOV, imm_desc(aval), 8'h00, 1'b0);
				apply(BRANCH_OPS[i], (r % 2 == 1) ? imm_desc(opnd) : pick_desc(0), opnd, 1'b0);
			end
		end
		finish_test("branch");

		apply(`ALU_MOV, imm_desc(8'h00), 8'h00, 1'b0);
		for (int i = 0; i < 12; i++)
			apply((i % 2 == 1) ? BRANCH_OPS[i % 6] : MOVE_OPS[i % 11], pick_desc(i % 3),
				rand_byte(), 1'b1);
		apply(`ALU_INC, pick_desc(0), rand_byte(), 1'b1);
		finish_test("nop");

		$display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end
		else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 10
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk; // free running.
	end

endmodule

`default_nettype wire
